// ==== src/cache_pkg.sv ====
package cache_pkg;

	// ----------------------------------------------------------------------
	// cache geometry
	// ----------------------------------------------------------------------
	localparam int ADDR_W       = 16;  // word address
	localparam int WORD_W       = 32;  // data word
	localparam int BLOCK_W      = 2;   // word offset, 4 words per block
	localparam int SET_W        = 3;   // 8 sets
	localparam int WAYS         = 2;
	localparam int WAY_W        = 1;
	localparam int TAG_W        = ADDR_W - SET_W - BLOCK_W;  // 11
	localparam int LINE_W       = SET_W + WAY_W;             // line = {way, set}
	localparam int BLOCK_ADDR_W = ADDR_W - BLOCK_W;          // 14

	// ----------------------------------------------------------------------
	// word address, decoded two ways
	// ----------------------------------------------------------------------
	typedef union packed {
		struct packed {
			logic [TAG_W-1:0]   tag;
			logic [SET_W-1:0]   set;
			logic [BLOCK_W-1:0] off;
		} tsw;  // lookup view for the tag and data stores
		struct packed {
			logic [BLOCK_ADDR_W-1:0] blk;
			logic [BLOCK_W-1:0]      off;
		} bw;   // block view for the memory side
	} cache_addr_u;

	// ----------------------------------------------------------------------
	// controller states
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,      // waiting for a core request
		LOOKUP,    // tag compare on the registered address
		WB_REQ,    // block write command to memory
		WB_READ,   // data store read of one victim word
		WB_SEND,   // victim word offered to memory
		FILL_REQ,  // block read command to memory
		FILL,      // fill words written into the victim line
		RESPOND    // answer held for the core
	} cache_state_e;

endpackage

// ==== src/word_counter.sv ====
module word_counter (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  logic                          clear_i,  // hold at offset 0
	input  logic                          step_i,   // one accepted word
	output logic [cache_pkg::BLOCK_W-1:0] word_off_o,
	output logic                          last_o
);

	import cache_pkg::*;

	logic [BLOCK_W-1:0] cnt_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			cnt_q <= '0;
		end else if (clear_i) begin
			cnt_q <= '0;
		end else if (step_i) begin
			cnt_q <= cnt_q + 1'b1;  // wraps to 0 after the last word
		end
	end

	assign word_off_o = cnt_q;
	assign last_o     = (cnt_q == {BLOCK_W{1'b1}});  // offset 3

endmodule

// ==== src/fifo_victim.sv ====
module fifo_victim (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic [cache_pkg::SET_W-1:0] set_i,
	input  logic                        advance_i,  // pulse after a tag install
	output logic [cache_pkg::WAY_W-1:0] victim_way_o
);

	import cache_pkg::*;

	// one round-robin pointer per set
	logic [WAY_W-1:0] ptr_q [2**SET_W];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < 2**SET_W; s++) begin
				ptr_q[s] <= '0;  // all sets start at way 0
			end
		end else if (advance_i) begin
			// two ways, so the next way is just the other one
			ptr_q[set_i] <= ptr_q[set_i] + 1'b1;
		end
	end

	assign victim_way_o = ptr_q[set_i];  // oldest fill in this set

endmodule

// ==== src/tag_store.sv ====
module tag_store (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  cache_pkg::cache_addr_u      addr_i,        // registered request address
	input  logic [cache_pkg::WAY_W-1:0] victim_way_i,
	input  logic                        install_i,     // write tag into victim way
	input  logic                        set_dirty_i,   // store hit
	input  logic [cache_pkg::WAY_W-1:0] hit_i,         // way to mark dirty
	output logic                        hit_o,
	output logic [cache_pkg::WAY_W-1:0] hit_way_o,
	output logic                        victim_dirty_o,
	output logic [cache_pkg::TAG_W-1:0] victim_tag_o
);

	import cache_pkg::*;

	logic [TAG_W-1:0]     tag_q [2**LINE_W];  // indexed by {way, set}
	logic [2**LINE_W-1:0] valid_q;
	logic [2**LINE_W-1:0] dirty_q;
	logic [WAYS-1:0]      match;
	logic [LINE_W-1:0]    victim_line;
	logic [LINE_W-1:0]    dirty_line;

	assign victim_line = {victim_way_i, addr_i.tsw.set};
	assign dirty_line  = {hit_i, addr_i.tsw.set};

	// ----------------------------------------------------------------------
	// two-way compare
	// ----------------------------------------------------------------------
	always_comb begin
		hit_way_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			match[w] = valid_q[{WAY_W'(w), addr_i.tsw.set}] &&
				(tag_q[{WAY_W'(w), addr_i.tsw.set}] == addr_i.tsw.tag);
			if (match[w]) begin
				hit_way_o = WAY_W'(w);
			end
		end
	end

	assign hit_o = |match;

	assign victim_dirty_o = dirty_q[victim_line];
	assign victim_tag_o   = tag_q[victim_line];  // writeback address source

	// ----------------------------------------------------------------------
	// line state
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (install_i) begin
				valid_q[victim_line] <= 1'b1;
				dirty_q[victim_line] <= 1'b0;  // fresh block is clean
			end
			if (set_dirty_i) begin
				dirty_q[dirty_line] <= 1'b1;
			end
		end
	end

	// tag words, meaningful only where valid
	always_ff @(posedge clock_i) begin
		if (install_i) begin
			tag_q[victim_line] <= addr_i.tsw.tag;
		end
	end

endmodule

// ==== src/data_store.sv ====
module data_store (
	input  logic                                          clock_i,
	input  logic [cache_pkg::LINE_W+cache_pkg::BLOCK_W-1:0] addr_i,  // {way, set, offset}
	input  logic                                          we_i,
	input  logic [cache_pkg::WORD_W-1:0]                  wdata_i,
	output logic [cache_pkg::WORD_W-1:0]                  rdata_o
);

	import cache_pkg::*;

	// 16 lines of 4 words
	logic [WORD_W-1:0] mem_q [2**(LINE_W+BLOCK_W)];

	always_ff @(posedge clock_i) begin
		if (we_i) begin
			mem_q[addr_i] <= wdata_i;
		end
		rdata_o <= mem_q[addr_i];  // old word on a same-cycle write
	end

endmodule

// ==== src/cache_fsm.sv ====
module cache_fsm (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	// core side
	input  logic                               core_req_valid_i,
	input  logic                               core_req_write_i,
	input  logic [cache_pkg::ADDR_W-1:0]       core_req_addr_i,
	input  logic [cache_pkg::WORD_W-1:0]       core_req_wdata_i,
	output logic                               core_req_ready_o,
	output logic                               core_resp_valid_o,
	output logic [cache_pkg::WORD_W-1:0]       core_resp_rdata_o,
	input  logic                               core_resp_ready_i,
	// memory side
	output logic                               mem_req_valid_o,
	output logic                               mem_req_write_o,
	output logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_req_addr_o,
	input  logic                               mem_req_ready_i,
	output logic                               mem_wdata_valid_o,
	output logic [cache_pkg::WORD_W-1:0]       mem_wdata_o,
	input  logic                               mem_wdata_ready_i,
	input  logic                               mem_rdata_valid_i,
	input  logic [cache_pkg::WORD_W-1:0]       mem_rdata_i,
	output logic                               mem_rdata_ready_o,
	// tag store and victim pointer
	input  logic                               hit_i,
	input  logic [cache_pkg::WAY_W-1:0]        hit_way_i,
	input  logic [cache_pkg::WAY_W-1:0]        victim_way_i,
	input  logic                               victim_dirty_i,
	input  logic [cache_pkg::TAG_W-1:0]        victim_tag_i,
	output cache_pkg::cache_addr_u             lookup_addr_o,
	output logic                               install_o,
	output logic                               set_dirty_o,
	output logic                               victim_advance_o,
	// data store
	input  logic [cache_pkg::WORD_W-1:0]       rd_data_i,
	output logic [cache_pkg::LINE_W-1:0]       line_o,
	output logic                               mem_we_o,
	output logic [cache_pkg::BLOCK_W-1:0]      mem_addr_line_o,   // word within the line
	output logic [cache_pkg::WORD_W-1:0]       mem_wdata_line_o,
	// word counter
	input  logic [cache_pkg::BLOCK_W-1:0]      word_off_i,
	input  logic                               word_last_i,
	output logic                               cnt_clear_o,
	output logic                               cnt_step_o,
	// events
	output logic                               flag_hit_o,
	output logic                               flag_miss_o,
	output logic                               flag_writeback_o
);

	import cache_pkg::*;

	cache_state_e state_q, state_d;
	logic         replay_q;  // replayed lookup raises no hit event
	cache_addr_u  req_addr_q;
	logic         req_write_q;
	logic [WORD_W-1:0] req_wdata_q;
	cache_addr_u  wb_addr;
	logic         in_block;   // victim line is being moved
	logic         fill_word;
	logic         wb_word;

	// ----------------------------------------------------------------------
	// state and request registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q  <= IDLE;
			replay_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == FILL && state_d == LOOKUP) replay_q <= 1'b1;
			else if (state_q == RESPOND && core_resp_ready_i) replay_q <= 1'b0;
		end
	end

	always_ff @(posedge clock_i) begin
		if (state_q == IDLE && core_req_valid_i) begin  // accept edge
			req_addr_q  <= core_req_addr_i;
			req_write_q <= core_req_write_i;
			req_wdata_q <= core_req_wdata_i;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:     if (core_req_valid_i) state_d = LOOKUP;
			LOOKUP: begin
				if (hit_i) state_d = RESPOND;
				else if (victim_dirty_i) state_d = WB_REQ;  // writeback before fill
				else state_d = FILL_REQ;
			end
			WB_REQ:   if (mem_req_ready_i) state_d = WB_READ;
			WB_READ:  state_d = WB_SEND;  // data store read latency
			WB_SEND: begin
				if (mem_wdata_ready_i) state_d = word_last_i ? FILL_REQ : WB_READ;
			end
			FILL_REQ: if (mem_req_ready_i) state_d = FILL;
			FILL:     if (mem_rdata_valid_i && word_last_i) state_d = LOOKUP;  // replay
			RESPOND:  if (core_resp_ready_i) state_d = IDLE;
			default:  state_d = IDLE;
		endcase
	end

	// ----------------------------------------------------------------------
	// datapath control
	// ----------------------------------------------------------------------
	always_comb begin
		wb_addr         = req_addr_q;
		wb_addr.tsw.tag = victim_tag_i;  // victim block lives under its own tag
	end

	assign in_block  = (state_q == WB_READ) || (state_q == WB_SEND) || (state_q == FILL);
	assign fill_word = (state_q == FILL) && mem_rdata_valid_i;
	assign wb_word   = (state_q == WB_SEND) && mem_wdata_ready_i;

	assign core_req_ready_o  = (state_q == IDLE);
	assign core_resp_valid_o = (state_q == RESPOND);
	assign core_resp_rdata_o = rd_data_i;  // address held through RESPOND

	assign mem_req_valid_o   = (state_q == WB_REQ) || (state_q == FILL_REQ);
	assign mem_req_write_o   = (state_q == WB_REQ);
	assign mem_req_addr_o    = mem_req_write_o ? wb_addr.bw.blk : req_addr_q.bw.blk;
	assign mem_wdata_valid_o = (state_q == WB_SEND);
	assign mem_wdata_o       = rd_data_i;
	assign mem_rdata_ready_o = (state_q == FILL);

	assign lookup_addr_o    = req_addr_q;
	assign install_o        = fill_word && word_last_i;  // last fill word installs the tag
	assign victim_advance_o = install_o;
	assign set_dirty_o      = (state_q == LOOKUP) && hit_i && req_write_q;

	assign line_o           = in_block ? {victim_way_i, req_addr_q.tsw.set}
		: {hit_way_i, req_addr_q.tsw.set};
	assign mem_addr_line_o  = in_block ? word_off_i : req_addr_q.tsw.off;
	assign mem_we_o         = set_dirty_o || fill_word;  // store hit or fill word
	assign mem_wdata_line_o = (state_q == FILL) ? mem_rdata_i : req_wdata_q;

	assign cnt_clear_o = (state_q == IDLE);
	assign cnt_step_o  = wb_word || fill_word;

	// event pulses
	assign flag_hit_o       = (state_q == LOOKUP) && hit_i && !replay_q;
	assign flag_miss_o      = (state_q == LOOKUP) && !hit_i;
	assign flag_writeback_o = (state_q == WB_REQ) && mem_req_ready_i;

endmodule

// ==== src/cache_top.sv ====
module cache_top (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	// core side
	input  logic                               core_req_valid_i,
	input  logic                               core_req_write_i,
	input  logic [cache_pkg::ADDR_W-1:0]       core_req_addr_i,
	input  logic [cache_pkg::WORD_W-1:0]       core_req_wdata_i,
	output logic                               core_req_ready_o,
	output logic                               core_resp_valid_o,
	output logic [cache_pkg::WORD_W-1:0]       core_resp_rdata_o,
	input  logic                               core_resp_ready_i,
	// memory side
	output logic                               mem_req_valid_o,
	output logic                               mem_req_write_o,
	output logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_req_addr_o,
	input  logic                               mem_req_ready_i,
	output logic                               mem_wdata_valid_o,
	output logic [cache_pkg::WORD_W-1:0]       mem_wdata_o,
	input  logic                               mem_wdata_ready_i,
	input  logic                               mem_rdata_valid_i,
	input  logic [cache_pkg::WORD_W-1:0]       mem_rdata_i,
	output logic                               mem_rdata_ready_o,
	// events
	output logic                               flag_hit_o,
	output logic                               flag_miss_o,
	output logic                               flag_writeback_o
);

	import cache_pkg::*;

	// ----------------------------------------------------------------------
	// internal nets
	// ----------------------------------------------------------------------
	cache_addr_u        lookup_addr;
	logic               hit;
	logic [WAY_W-1:0]   hit_way;
	logic [WAY_W-1:0]   victim_way;
	logic               victim_dirty;
	logic [TAG_W-1:0]   victim_tag;
	logic               install;
	logic               set_dirty;
	logic               victim_advance;
	logic [LINE_W-1:0]  line;
	logic               data_we;
	logic [BLOCK_W-1:0] data_off;
	logic [WORD_W-1:0]  data_wdata;
	logic [WORD_W-1:0]  data_rdata;
	logic [BLOCK_W-1:0] word_off;
	logic               word_last;
	logic               cnt_clear;
	logic               cnt_step;

	cache_fsm u_fsm (
		.clock_i           (clock_i),
		.resetn_i          (resetn_i),
		.core_req_valid_i  (core_req_valid_i),
		.core_req_write_i  (core_req_write_i),
		.core_req_addr_i   (core_req_addr_i),
		.core_req_wdata_i  (core_req_wdata_i),
		.core_req_ready_o  (core_req_ready_o),
		.core_resp_valid_o (core_resp_valid_o),
		.core_resp_rdata_o (core_resp_rdata_o),
		.core_resp_ready_i (core_resp_ready_i),
		.mem_req_valid_o   (mem_req_valid_o),
		.mem_req_write_o   (mem_req_write_o),
		.mem_req_addr_o    (mem_req_addr_o),
		.mem_req_ready_i   (mem_req_ready_i),
		.mem_wdata_valid_o (mem_wdata_valid_o),
		.mem_wdata_o       (mem_wdata_o),
		.mem_wdata_ready_i (mem_wdata_ready_i),
		.mem_rdata_valid_i (mem_rdata_valid_i),
		.mem_rdata_i       (mem_rdata_i),
		.mem_rdata_ready_o (mem_rdata_ready_o),
		.hit_i             (hit),
		.hit_way_i         (hit_way),
		.victim_way_i      (victim_way),
		.victim_dirty_i    (victim_dirty),
		.victim_tag_i      (victim_tag),
		.lookup_addr_o     (lookup_addr),
		.install_o         (install),
		.set_dirty_o       (set_dirty),
		.victim_advance_o  (victim_advance),
		.rd_data_i         (data_rdata),
		.line_o            (line),
		.mem_we_o          (data_we),
		.mem_addr_line_o   (data_off),
		.mem_wdata_line_o  (data_wdata),
		.word_off_i        (word_off),
		.word_last_i       (word_last),
		.cnt_clear_o       (cnt_clear),
		.cnt_step_o        (cnt_step),
		.flag_hit_o        (flag_hit_o),
		.flag_miss_o       (flag_miss_o),
		.flag_writeback_o  (flag_writeback_o)
	);

	word_counter u_counter (
		.clock_i    (clock_i),
		.resetn_i   (resetn_i),
		.clear_i    (cnt_clear),
		.step_i     (cnt_step),
		.word_off_o (word_off),
		.last_o     (word_last)
	);

	fifo_victim u_victim (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.set_i        (lookup_addr.tsw.set),
		.advance_i    (victim_advance),
		.victim_way_o (victim_way)
	);

	tag_store u_tags (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.addr_i         (lookup_addr),
		.victim_way_i   (victim_way),
		.install_i      (install),
		.set_dirty_i    (set_dirty),
		.hit_i          (hit_way),  // dirty the way that matched
		.hit_o          (hit),
		.hit_way_o      (hit_way),
		.victim_dirty_o (victim_dirty),
		.victim_tag_o   (victim_tag)
	);

	data_store u_data (
		.clock_i (clock_i),
		.addr_i  ({line, data_off}),
		.we_i    (data_we),
		.wdata_i (data_wdata),
		.rdata_o (data_rdata)
	);

endmodule

// ==== tb/main_mem_model.sv ====
module main_mem_model (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	input  logic                               mem_req_valid_i,
	input  logic                               mem_req_write_i,
	input  logic [cache_pkg::BLOCK_ADDR_W-1:0] mem_req_addr_i,
	output logic                               mem_req_ready_o,
	input  logic                               mem_wdata_valid_i,
	input  logic [cache_pkg::WORD_W-1:0]       mem_wdata_i,
	output logic                               mem_wdata_ready_o,
	output logic                               mem_rdata_valid_o,
	output logic [cache_pkg::WORD_W-1:0]       mem_rdata_o,
	input  logic                               mem_rdata_ready_i,
	// traffic record for the testbench
	output int                                 wr_reqs_o,
	output int                                 rd_reqs_o,
	output int                                 wr_seq_o,   // request number of last write
	output int                                 rd_seq_o,   // request number of last read
	output logic [cache_pkg::BLOCK_ADDR_W-1:0] wr_blk_o,
	output logic [cache_pkg::BLOCK_ADDR_W-1:0] rd_blk_o,
	output logic                               idle_o,
	output int                                 errors_o
);
	timeunit 1ns;
	timeprecision 1ps;

	import cache_pkg::*;

	localparam logic [WORD_W-1:0] MEM_PATTERN = 32'hC0DE_5A5A;

	logic [WORD_W-1:0]       mem_q [2**ADDR_W];
	logic [15:0]             lfsr_q       = 16'd38043;
	logic                    req_ready_q  = 1'b0;
	logic                    wd_ready_q   = 1'b0;
	logic                    rd_valid_q   = 1'b0;
	logic [WORD_W-1:0]       rd_data_q    = '0;
	logic                    wr_open      = 1'b0;  // writeback words still due
	logic                    rd_open      = 1'b0;  // fill words still due
	int                      widx;
	int                      ridx;
	int                      seq;
	// values seen at the falling edge, used on the next rising edge
	logic                    req_fire, req_wait, req_write_s;
	logic [BLOCK_ADDR_W-1:0] req_addr_s;
	logic                    wd_fire, wd_wait, rd_fire;
	logic [WORD_W-1:0]       wd_s;

	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois, x^16+x^14+x^13+x^11+1
	endfunction

	function automatic logic take_bit();
		lfsr_q = next_lfsr(lfsr_q);
		return lfsr_q[0];
	endfunction

	initial begin
		for (int a = 0; a < 2**ADDR_W; a++) begin
			mem_q[a] = WORD_W'(a) ^ MEM_PATTERN;  // every word differs
		end
	end

	assign mem_req_ready_o   = req_ready_q;
	assign mem_wdata_ready_o = wd_ready_q;
	assign mem_rdata_valid_o = rd_valid_q;
	assign mem_rdata_o       = rd_data_q;
	assign idle_o            = !wr_open && !rd_open;

	// ------------------------------------------------------------------
	// traffic checks, mid cycle
	// ------------------------------------------------------------------
	always @(negedge clock_i) begin
		if (resetn_i) begin
			if (req_wait) begin
				assert (mem_req_valid_i && mem_req_write_i == req_write_s &&
					mem_req_addr_i == req_addr_s) else begin
					$display("FAIL %0t: block request changed while stalled", $time);
					errors_o++;
				end
			end
			if (wd_wait) begin
				assert (mem_wdata_valid_i && mem_wdata_i == wd_s) else begin
					$display("FAIL %0t: writeback word changed while stalled", $time);
					errors_o++;
				end
			end
			assert (!(mem_req_valid_i && req_ready_q) || idle_o) else begin
				$display("memory model: new block request before 4 words of the last one");
				errors_o++;
			end
			assert (!(mem_wdata_valid_i && wd_ready_q) || wr_open) else begin
				$display("memory model: writeback word arrived with no open write request");
				errors_o++;
			end
		end
		req_fire    = resetn_i && mem_req_valid_i && req_ready_q;
		req_wait    = resetn_i && mem_req_valid_i && !req_ready_q;
		req_write_s = mem_req_write_i;
		req_addr_s  = mem_req_addr_i;
		wd_fire     = resetn_i && mem_wdata_valid_i && wd_ready_q;
		wd_wait     = resetn_i && mem_wdata_valid_i && !wd_ready_q;
		wd_s        = mem_wdata_i;
		rd_fire     = resetn_i && rd_valid_q && mem_rdata_ready_i;
	end

	// ------------------------------------------------------------------
	// responder
	// ------------------------------------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			req_ready_q <= 1'b0;
			wd_ready_q  <= 1'b0;
			rd_valid_q  <= 1'b0;
			wr_open     = 1'b0;
			rd_open     = 1'b0;
			seq         = 0;
			wr_reqs_o   = 0;
			rd_reqs_o   = 0;
			wr_seq_o    = 0;
			rd_seq_o    = 0;
		end else begin
			if (wd_fire) begin
				mem_q[{wr_blk_o, 2'(widx)}] = wd_s;  // offset order
				widx++;
				if (widx == 4) wr_open = 1'b0;
			end
			if (rd_fire) begin
				ridx++;
				if (ridx == 4) rd_open = 1'b0;
			end
			if (req_fire) begin
				seq++;
				if (req_write_s) begin
					wr_open   = 1'b1;
					widx      = 0;
					wr_blk_o  = req_addr_s;
					wr_reqs_o++;
					wr_seq_o  = seq;
				end else begin
					rd_open   = 1'b1;
					ridx      = 0;
					rd_blk_o  = req_addr_s;
					rd_reqs_o++;
					rd_seq_o  = seq;
				end
			end
			req_ready_q <= take_bit();  // random stalls
			wd_ready_q  <= take_bit();
			if (!rd_open) begin
				rd_valid_q <= 1'b0;
			end else if (!(rd_valid_q && !rd_fire)) begin  // offered word holds
				rd_valid_q <= take_bit();
				rd_data_q  <= mem_q[{rd_blk_o, 2'(ridx)}];
			end
		end
	end

endmodule

// ==== tb/cache_tb.sv ====
module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cache_pkg::*;

	localparam int                N_REQ       = 400;
	localparam int                CLK_PERIOD  = 40;
	localparam int                CYC_PER_REQ = 40;   // budget per request
	localparam logic [7:0]        WINDOW_HI   = 8'hA7;  // upper tag bits of the window
	localparam logic [WORD_W-1:0] MEM_PATTERN = 32'hC0DE_5A5A;

	logic                    clock_i = 1'b0;
	logic                    resetn_i;
	logic                    core_req_valid, core_req_write, core_resp_ready;
	logic [ADDR_W-1:0]       core_req_addr;
	logic [WORD_W-1:0]       core_req_wdata;
	logic                    core_req_ready_o, core_resp_valid_o;
	logic [WORD_W-1:0]       core_resp_rdata_o;
	logic                    mem_req_valid, mem_req_write, mem_req_ready;
	logic [BLOCK_ADDR_W-1:0] mem_req_addr;
	logic                    mem_wdata_valid, mem_wdata_ready;
	logic [WORD_W-1:0]       mem_wdata, mem_rdata;
	logic                    mem_rdata_valid, mem_rdata_ready;
	logic                    flag_hit_o, flag_miss_o, flag_writeback_o;
	int                      wr_reqs, rd_reqs, wr_seq, rd_seq, mem_errors;
	logic [BLOCK_ADDR_W-1:0] wr_blk, rd_blk;
	logic                    mem_idle;

	// reference model
	logic [WORD_W-1:0]       ref_mem [2**ADDR_W];
	logic [TAG_W-1:0]        ref_tag [2**SET_W][WAYS];
	logic                    ref_valid [2**SET_W][WAYS];
	logic                    ref_dirty [2**SET_W][WAYS];
	logic [WAY_W-1:0]        ref_ptr [2**SET_W];
	logic [15:0]             lfsr_q = 16'd38043;
	int                      errors;

	cache_top uut (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.core_req_valid_i(core_req_valid), .core_req_write_i(core_req_write),
		.core_req_addr_i(core_req_addr), .core_req_wdata_i(core_req_wdata),
		.core_req_ready_o(core_req_ready_o), .core_resp_valid_o(core_resp_valid_o),
		.core_resp_rdata_o(core_resp_rdata_o), .core_resp_ready_i(core_resp_ready),
		.mem_req_valid_o(mem_req_valid), .mem_req_write_o(mem_req_write),
		.mem_req_addr_o(mem_req_addr), .mem_req_ready_i(mem_req_ready),
		.mem_wdata_valid_o(mem_wdata_valid), .mem_wdata_o(mem_wdata),
		.mem_wdata_ready_i(mem_wdata_ready), .mem_rdata_valid_i(mem_rdata_valid),
		.mem_rdata_i(mem_rdata), .mem_rdata_ready_o(mem_rdata_ready),
		.flag_hit_o(flag_hit_o), .flag_miss_o(flag_miss_o),
		.flag_writeback_o(flag_writeback_o)
	);

	main_mem_model u_mem (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.mem_req_valid_i(mem_req_valid), .mem_req_write_i(mem_req_write),
		.mem_req_addr_i(mem_req_addr), .mem_req_ready_o(mem_req_ready),
		.mem_wdata_valid_i(mem_wdata_valid), .mem_wdata_i(mem_wdata),
		.mem_wdata_ready_o(mem_wdata_ready), .mem_rdata_valid_o(mem_rdata_valid),
		.mem_rdata_o(mem_rdata), .mem_rdata_ready_i(mem_rdata_ready),
		.wr_reqs_o(wr_reqs), .rd_reqs_o(rd_reqs), .wr_seq_o(wr_seq), .rd_seq_o(rd_seq),
		.wr_blk_o(wr_blk), .rd_blk_o(rd_blk), .idle_o(mem_idle), .errors_o(mem_errors)
	);

	initial begin
		forever #(CLK_PERIOD/2) clock_i = ~clock_i;
	end

	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois, same taps as memory
	endfunction

	function automatic logic take_bit();
		lfsr_q = next_lfsr(lfsr_q);
		return lfsr_q[0];
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], take_bit()};  // one step per bit
		end
		return v;
	endfunction

	task automatic log_mismatch(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		errors++;
	endtask

	// ------------------------------------------------------------------
	// one core request, predicted by the model and then checked
	// ------------------------------------------------------------------
	task automatic run_request(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] wdata);
		cache_addr_u             a;
		logic                    exp_hit, exp_wb, done;
		logic [WAY_W-1:0]        way;
		logic [BLOCK_ADDR_W-1:0] wb_blk;
		logic [WORD_W-1:0]       exp_data;
		int                      wr0, rd0, hits, misses, wbs, k, first_k;
		a       = addr;
		exp_hit = 1'b0;
		way     = ref_ptr[a.tsw.set];  // fifo victim unless it hits
		for (int w = 0; w < WAYS; w++) begin
			if (ref_valid[a.tsw.set][w] && ref_tag[a.tsw.set][w] == a.tsw.tag) begin
				exp_hit = 1'b1;
				way     = WAY_W'(w);
			end
		end
		exp_wb = !exp_hit && ref_dirty[a.tsw.set][way];
		wb_blk = {ref_tag[a.tsw.set][way], a.tsw.set};
		if (!exp_hit) begin  // install, fresh block is clean
			ref_tag[a.tsw.set][way]   = a.tsw.tag;
			ref_valid[a.tsw.set][way] = 1'b1;
			ref_dirty[a.tsw.set][way] = 1'b0;
			ref_ptr[a.tsw.set]        = ref_ptr[a.tsw.set] + 1'b1;
		end
		if (wr) begin
			ref_dirty[a.tsw.set][way] = 1'b1;
			ref_mem[addr]             = wdata;
		end
		exp_data = ref_mem[addr];
		wr0 = wr_reqs;
		rd0 = rd_reqs;
		hits = 0;
		misses = 0;
		wbs = 0;
		@(posedge clock_i);
		core_req_valid <= 1'b1;
		core_req_write <= wr;
		core_req_addr  <= addr;
		core_req_wdata <= wdata;
		@(negedge clock_i);
		while (!core_req_ready_o) @(negedge clock_i);
		@(posedge clock_i);  // accept edge
		core_req_valid  <= 1'b0;
		core_resp_ready <= take_bit();
		k = 0;
		first_k = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clock_i);
			k++;
			if (flag_hit_o) hits++;
			if (flag_miss_o) misses++;
			if (flag_writeback_o) wbs++;
			if (first_k != 0) begin
				assert (core_resp_valid_o) else begin
					$display("core response was withdrawn before it was taken");
					errors++;
				end
			end
			if (core_resp_valid_o) begin
				if (first_k == 0) first_k = k;
				if (!wr) begin
					assert (core_resp_rdata_o == exp_data) else
						log_mismatch($sformatf("load %h read %h, expected %h",
							addr, core_resp_rdata_o, exp_data));
				end
				done = core_resp_ready;
			end
			@(posedge clock_i);
			if (!done) core_resp_ready <= take_bit();  // random response stalls
		end
		@(negedge clock_i);
		assert (hits == (exp_hit ? 1 : 0) && misses == (exp_hit ? 0 : 1)) else
			log_mismatch($sformatf("addr %h hit/miss pulses %0d/%0d, model hit %0b",
				addr, hits, misses, exp_hit));
		if (exp_hit) begin
			assert (first_k == 2) else
				log_mismatch($sformatf("hit answered after %0d cycles", first_k));
		end
		assert (wbs == (exp_wb ? 1 : 0) && wr_reqs - wr0 == (exp_wb ? 1 : 0)) else
			log_mismatch($sformatf("addr %h writeback pulses %0d, writes %0d, model %0b",
				addr, wbs, wr_reqs - wr0, exp_wb));
		assert (rd_reqs - rd0 == (exp_hit ? 0 : 1)) else
			log_mismatch($sformatf("addr %h issued %0d fills", addr, rd_reqs - rd0));
		if (!exp_hit) begin
			assert (rd_blk == a.bw.blk) else
				log_mismatch($sformatf("fill of block %h, expected %h", rd_blk, a.bw.blk));
		end
		if (exp_wb) begin
			assert (wr_blk == wb_blk && wr_seq < rd_seq) else
				log_mismatch($sformatf("writeback block %h, expected %h before the fill",
					wr_blk, wb_blk));
			for (int i = 0; i < 4; i++) begin
				assert (u_mem.mem_q[{wb_blk, 2'(i)}] == ref_mem[{wb_blk, 2'(i)}]) else
					log_mismatch($sformatf("written back word %0d of block %h wrong", i, wb_blk));
			end
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
		resetn_i        = 1'b0;
		core_req_valid  = 1'b0;
		core_req_write  = 1'b0;
		core_req_addr   = '0;
		core_req_wdata  = '0;
		core_resp_ready = 1'b0;
		errors          = 0;
		for (int a = 0; a < 2**ADDR_W; a++) begin
			ref_mem[a] = WORD_W'(a) ^ MEM_PATTERN;  // initial memory contents
		end
		for (int s = 0; s < 2**SET_W; s++) begin
			ref_ptr[s] = '0;
			for (int w = 0; w < WAYS; w++) begin
				ref_tag[s][w]   = '0;
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
			end
		end
		repeat (5) @(posedge clock_i);
		resetn_i <= 1'b1;
		@(negedge clock_i);
		assert (core_req_ready_o && !core_resp_valid_o && !mem_req_valid &&
			!mem_wdata_valid && !mem_rdata_ready && !flag_hit_o && !flag_miss_o &&
			!flag_writeback_o) else
			log_mismatch("outputs after reset not at their idle values");
		for (int n = 0; n < N_REQ; n++) begin
			wr    = take_bit();  // half loads, half stores
			addr  = {WINDOW_HI, 6'(take_bits(6)), 2'(take_bits(2))};  // 64 blocks
			wdata = take_bits(32);
			run_request(wr, addr, wdata);
		end
		assert (mem_idle) else begin
			$display("memory model still has an open block transfer at the end");
			errors++;
		end
		$display("errors: testbench %0d, memory model %0d", errors, mem_errors);
		if (errors == 0 && mem_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(N_REQ * CYC_PER_REQ * CLK_PERIOD);
		$display("timeout: %0d requests did not finish in %0d cycles each", N_REQ, CYC_PER_REQ);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== cache_ctrl.f ====
src/cache_pkg.sv
src/word_counter.sv
src/fifo_victim.sv
src/tag_store.sv
src/data_store.sv
src/cache_fsm.sv
src/cache_top.sv
tb/main_mem_model.sv
tb/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=sim_build
LOG=sim.log
TOP=cache_tb

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$TOP" --Mdir "$BUILD_DIR" -f cache_ctrl.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
	echo "run passed"
	exit 0
else
	echo "run failed, see $LOG"
	exit 1
fi
